// ==== Bender.yml ====
package:
  name: convolve

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - g729ArithPkg.sv
      - convMemPkg.sv
      - scratchMem.sv
      - satShifter.sv
      - memArbiter.sv
      - apbHostPort.sv
      - convolve.sv
      - convolveTop.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - convolve_assertions.sv
      - tb_convolveTop.sv

// ==== apbHostPort.sv ====
`timescale 1ns/1ps
`include "convolve_settings.svh"

module apbHostPort (
	input logic clk,
	input logic reset,
	input convMemPkg::apbReq_t apbReq,
	output convMemPkg::apbRsp_t apbRsp,
	output convMemPkg::memReq_t memReq,
	input logic memGrant,
	input convMemPkg::memRsp_t memRsp,
	output logic start,
	output convMemPkg::blockIdx xBase,
	output convMemPkg::blockIdx hBase,
	output convMemPkg::blockIdx yBase,
	input logic busy,
	input logic engDone
);
	import convMemPkg::*;

	apbState_e state;
	logic window;
	logic inAccess;
	logic regWrite;
	logic regErr;
	logic doneFlag;
	regAddr regSel;
	apbData regRdata;
	status_t status;

	assign window = apbReq.paddr[`CONV_MEM_WINDOW];
	assign regSel = apbReq.paddr[`CONV_MEM_WINDOW-1:0];
	assign inAccess = state == access && apbReq.psel && apbReq.penable;
	assign regWrite = inAccess && !window && apbReq.pwrite && !regErr;
	assign status.done = doneFlag;
	assign status.busy = busy;

	////////////////////////////////////////
	// Register decode
	////////////////////////////////////////

	always_comb
	begin
		regRdata = '0;
		regErr = 1'b0;
		case (regSel)
			regCtrl:
				regRdata = '0;
			regStatus:
			begin
				regRdata = apbData'(status);
				regErr = apbReq.pwrite;
			end
			regXBase:
				regRdata = apbData'(xBase);
			regHBase:
				regRdata = apbData'(hBase);
			regYBase:
				regRdata = apbData'(yBase);
			default:
				regErr = 1'b1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			xBase <= '0;
			hBase <= '0;
			yBase <= '0;
			start <= 1'b0;
			doneFlag <= 1'b0;
		end
		else
		begin
			start <= regWrite && regSel == regCtrl && apbReq.pwdata[0];
			if (regWrite && regSel == regXBase)
				xBase <= blockIdx'(apbReq.pwdata);
			if (regWrite && regSel == regHBase)
				hBase <= blockIdx'(apbReq.pwdata);
			if (regWrite && regSel == regYBase)
				yBase <= blockIdx'(apbReq.pwdata);
			// A start the engine accepts clears the sticky flag
			if (start && !busy)
				doneFlag <= 1'b0;
			else if (engDone)
				doneFlag <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Transfer sequencing
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= apbIdle;
		else
		begin
			case (state)
				apbIdle:
					if (apbReq.psel && !apbReq.penable)
						state <= access;
				access:
					if (inAccess)
					begin
						if (!window || (apbReq.pwrite && memGrant))
							state <= apbIdle;
						else if (memGrant)
							state <= memWait;
					end
				memWait:
					if (memRsp.rvalid)
						state <= apbIdle;
				default:
					state <= apbIdle;
			endcase
		end
	end

	// Window request held through the access phase until granted
	always_comb
	begin
		memReq = '0;
		if (inAccess && window)
		begin
			memReq.valid = 1'b1;
			memReq.write = apbReq.pwrite;
			memReq.addr = apbReq.paddr[`CONV_ADDR_W-1:0];
			memReq.wdata = apbReq.pwdata;
		end
	end

	always_comb
	begin
		apbRsp = '0;
		if (state == memWait)
		begin
			apbRsp.pready = memRsp.rvalid;
			apbRsp.prdata = memRsp.rdata;
		end
		else if (inAccess && !window)
		begin
			apbRsp.pready = 1'b1;
			apbRsp.pslverr = regErr;
			apbRsp.prdata = regRdata;
		end
		else if (inAccess && apbReq.pwrite)
			apbRsp.pready = memGrant;
	end

endmodule

// ==== convMemPkg.sv ====
`include "convolve_settings.svh"

package convMemPkg;

	typedef logic [`CONV_ADDR_W-1:0] memAddr;
	typedef logic [`CONV_BLOCK_W-1:0] blockIdx;
	typedef logic [`CONV_MEM_WINDOW:0] apbAddr;
	typedef logic [`CONV_MEM_WINDOW-1:0] regAddr;
	typedef logic [15:0] apbData;

	////////////////////////////////////////
	// Scratch memory port
	////////////////////////////////////////

	typedef struct packed {
		logic valid;
		logic write;
		memAddr addr;
		g729ArithPkg::word16 wdata;
	} memReq_t;

	typedef struct packed {
		logic rvalid;
		g729ArithPkg::word16 rdata;
	} memRsp_t;

	////////////////////////////////////////
	// APB host side
	////////////////////////////////////////

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		apbAddr paddr;
		apbData pwdata;
	} apbReq_t;

	typedef struct packed {
		logic pready;
		logic pslverr;
		apbData prdata;
	} apbRsp_t;

	// Done lands on bit 1, busy on bit 0
	typedef struct packed {
		logic done;
		logic busy;
	} status_t;

	localparam regAddr regCtrl = 'd0;
	localparam regAddr regStatus = 'd1;
	localparam regAddr regXBase = 'd2;
	localparam regAddr regHBase = 'd3;
	localparam regAddr regYBase = 'd4;

	typedef enum logic [2:0] {
		convIdle,
		outerLoop,
		innerLoop,
		readX,
		readH,
		macStep,
		shiftWait,
		writeY
	} convState_e;

	typedef enum logic [1:0] {
		apbIdle,
		access,
		memWait
	} apbState_e;

endpackage

// ==== convolve.sv ====
`timescale 1ns/1ps
`include "convolve_settings.svh"

module convolve (
	input logic clk,
	input logic reset,
	input logic start,
	input convMemPkg::blockIdx xBase,
	input convMemPkg::blockIdx hBase,
	input convMemPkg::blockIdx yBase,
	output convMemPkg::memReq_t memReq,
	input logic memGrant,
	input convMemPkg::memRsp_t memRsp,
	output g729ArithPkg::word32 shiftIn,
	output logic shiftReady,
	input g729ArithPkg::word32 shiftOut,
	input logic shiftDone,
	output logic busy,
	output logic done
);
	import g729ArithPkg::*;
	import convMemPkg::*;

	localparam int idxW = `CONV_ADDR_W - `CONV_BLOCK_W;
	localparam logic [idxW-1:0] lastIdx = idxW'(`CONV_VEC_LEN - 1);

	convState_e state;
	logic [idxW-1:0] n;
	logic [idxW-1:0] i;
	logic [idxW-1:0] hIdx;
	logic sumDone;
	word32 acc;
	word16 xVal;

	// Offset of h[n-i] inside its block
	assign hIdx = n - i;
	assign sumDone = i > n;
	assign busy = state != convIdle;

	////////////////////////////////////////
	// Loop control
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= convIdle;
			n <= '0;
			i <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				convIdle:
					if (start)
					begin
						n <= '0;
						state <= outerLoop;
					end
				outerLoop:
				begin
					i <= '0;
					state <= innerLoop;
				end
				innerLoop:
					state <= sumDone ? shiftWait : readX;
				readX:
					if (memGrant)
						state <= readH;
				readH:
					if (memGrant)
						state <= macStep;
				macStep:
					if (memRsp.rvalid)
					begin
						i <= i + 1'b1;
						state <= innerLoop;
					end
				shiftWait:
					if (shiftDone)
						state <= writeY;
				writeY:
					if (memGrant)
					begin
						if (n == lastIdx)
						begin
							done <= 1'b1;
							state <= convIdle;
						end
						else
						begin
							n <= n + 1'b1;
							state <= outerLoop;
						end
					end
				default:
					state <= convIdle;
			endcase
		end
	end

	// Accumulator and the x sample of the current term
	always_ff @(posedge clk)
	begin
		if (state == outerLoop)
			acc <= '0;
		else if (state == macStep && memRsp.rvalid)
			acc <= macSat(acc, xVal, memRsp.rdata);
		// x data shows up while the h read is pending
		if (state == readH && memRsp.rvalid)
			xVal <= memRsp.rdata;
	end

	////////////////////////////////////////
	// Memory requests
	////////////////////////////////////////

	always_comb
	begin
		memReq = '0;
		case (state)
			readX:
			begin
				memReq.valid = 1'b1;
				memReq.addr = {xBase, i};
			end
			readH:
			begin
				memReq.valid = 1'b1;
				memReq.addr = {hBase, hIdx};
			end
			writeY:
			begin
				memReq.valid = 1'b1;
				memReq.write = 1'b1;
				memReq.addr = {yBase, n};
				// Shifter output holds until the next ready
				memReq.wdata = shiftOut[31:16];
			end
			default:
				memReq = '0;
		endcase
	end

	// Hand the finished sum to the shifter
	assign shiftIn = acc;
	assign shiftReady = state == innerLoop && sumDone;

endmodule

// ==== convolveTop.sv ====
`timescale 1ns/1ps

module convolveTop (
	input logic clk,
	input logic reset,
	input convMemPkg::apbReq_t apbReq,
	output convMemPkg::apbRsp_t apbRsp
);
	import g729ArithPkg::*;
	import convMemPkg::*;

	memReq_t hostReq;
	memReq_t engReq;
	memReq_t memCmd;
	memRsp_t hostRsp;
	memRsp_t engRsp;
	logic hostGrant;
	logic engGrant;
	word16 memRdata;
	word32 shiftIn;
	word32 shiftOut;
	logic shiftReady;
	logic shiftDone;
	logic start;
	logic busy;
	logic engDone;
	blockIdx xBase;
	blockIdx hBase;
	blockIdx yBase;

	////////////////////////////////////////
	// Peers
	////////////////////////////////////////

	apbHostPort hostPort0 (
		.clk(clk),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.memReq(hostReq),
		.memGrant(hostGrant),
		.memRsp(hostRsp),
		.start(start),
		.xBase(xBase),
		.hBase(hBase),
		.yBase(yBase),
		.busy(busy),
		.engDone(engDone)
	);

	convolve conv0 (
		.clk(clk),
		.reset(reset),
		.start(start),
		.xBase(xBase),
		.hBase(hBase),
		.yBase(yBase),
		.memReq(engReq),
		.memGrant(engGrant),
		.memRsp(engRsp),
		.shiftIn(shiftIn),
		.shiftReady(shiftReady),
		.shiftOut(shiftOut),
		.shiftDone(shiftDone),
		.busy(busy),
		.done(engDone)
	);

	satShifter shift0 (
		.clk(clk),
		.reset(reset),
		.ready(shiftReady),
		.value(shiftIn),
		.result(shiftOut),
		.done(shiftDone)
	);

	// Shared scratch memory
	memArbiter arb0 (
		.clk(clk),
		.reset(reset),
		.hostReq(hostReq),
		.engReq(engReq),
		.hostGrant(hostGrant),
		.engGrant(engGrant),
		.hostRsp(hostRsp),
		.engRsp(engRsp),
		.memCmd(memCmd),
		.memRdata(memRdata)
	);

	scratchMem mem0 (
		.clk(clk),
		.cmd(memCmd),
		.rdata(memRdata)
	);

endmodule

// ==== convolve_assertions.sv ====
`timescale 1ns/1ps
`include "convolve_settings.svh"

module convolve_assertions (
	input logic clk,
	input logic reset,
	input convMemPkg::memReq_t hostReq,
	input convMemPkg::memReq_t engReq,
	input logic hostGrant,
	input logic engGrant,
	input convMemPkg::memReq_t memCmd,
	input convMemPkg::apbReq_t apbReq,
	input convMemPkg::apbRsp_t apbRsp,
	input logic shiftReady,
	input logic shiftDone
);

	////////////////////////////////////////
	// Arbiter
	////////////////////////////////////////

	grantsExclusive: assert property (@(posedge clk) disable iff (reset)
		!(hostGrant && engGrant))
		else $error("host and engine granted in the same cycle");

	// A write reaching the memory must come from the granted side
	writeGranted: assert property (@(posedge clk) disable iff (reset)
		(memCmd.valid && memCmd.write) |->
		((hostGrant && hostReq.write) || (engGrant && engReq.write)))
		else $error("memory write without a granted writer");

	////////////////////////////////////////
	// APB port and shifter
	////////////////////////////////////////

	readyInAccess: assert property (@(posedge clk) disable iff (reset)
		apbRsp.pready |-> (apbReq.psel && apbReq.penable))
		else $error("PREADY outside an access phase");

	// Shifter answers a fixed number of cycles after ready
	shiftDoneAfterReady: assert property (@(posedge clk) disable iff (reset)
		shiftDone |-> $past(shiftReady, `CONV_SHIFT + 1))
		else $error("shifter done without a preceding ready");

endmodule

// ==== convolve_input.txt ====
// Per case: xBase hBase yBase, then x[0..39], h[0..39] and expected y[0..39], 20 words a line
// Last section: four unmapped register addresses for the error probe
// Case A, small values, y[n] = h[n] + 2*h[n-1]
0001 0002 0003
1000 2000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
fff6 fff7 fff8 fff9 fffa fffb fffc fffd fffe ffff 0000 0001 0002 0003 0004 0005 0006 0007 0008 0009
000a 000b 000c 000d 000e 000f 0010 0011 0012 0013 0014 0015 0016 0017 0018 0019 001a 001b 001c 001d
fff6 ffe3 ffe6 ffe9 ffec ffef fff2 fff5 fff8 fffb fffe 0001 0004 0007 000a 000d 0010 0013 0016 0019
001c 001f 0022 0025 0028 002b 002e 0031 0034 0037 003a 003d 0040 0043 0046 0049 004c 004f 0052 0055
// Case B, every sample -1.0, every sum saturates
0004 0005 0006
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
// Unmapped register addresses
0005 0007 0fff 0010

// ==== convolve_settings.svh ====
`ifndef CONVOLVE_SETTINGS_SVH
`define CONVOLVE_SETTINGS_SVH

// Vector length L of x, h and y
`define CONV_VEC_LEN 40

// Scratch memory address width, 2048 words
`define CONV_ADDR_W 11

// Block index width, each vector sits in its own 64-word block
`define CONV_BLOCK_W 5

// Final scaling of each sum
`define CONV_SHIFT 3

// APB address bit that selects the memory window
`define CONV_MEM_WINDOW 12

`endif

// ==== g729ArithPkg.sv ====
package g729ArithPkg;

	// Q15 sample and Q31 accumulator
	typedef logic signed [15:0] word16;
	typedef logic signed [31:0] word32;

	localparam word16 minWord16 = 16'sh8000;
	localparam word32 maxWord32 = 32'sh7fff_ffff;
	localparam word32 minWord32 = 32'sh8000_0000;

	////////////////////////////////////////
	// Saturating fractional primitives
	////////////////////////////////////////

	// 2*a*b, only -1 * -1 overflows
	function automatic word32 multSat(input word16 a, input word16 b);
		word32 prod;
		prod = a * b;
		if (a == minWord16 && b == minWord16)
			return maxWord32;
		return prod <<< 1;
	endfunction

	function automatic word32 addSat(input word32 a, input word32 b);
		logic signed [32:0] sum;
		sum = a + b;
		// Carry out differs from sign bit on overflow
		if (sum[32] != sum[31])
			return sum[32] ? minWord32 : maxWord32;
		return sum[31:0];
	endfunction

	// Codec style multiply-accumulate
	function automatic word32 macSat(input word32 acc, input word16 a, input word16 b);
		return addSat(acc, multSat(a, b));
	endfunction

endpackage

// ==== memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
	input logic clk,
	input logic reset,
	input convMemPkg::memReq_t hostReq,
	input convMemPkg::memReq_t engReq,
	output logic hostGrant,
	output logic engGrant,
	output convMemPkg::memRsp_t hostRsp,
	output convMemPkg::memRsp_t engRsp,
	output convMemPkg::memReq_t memCmd,
	input g729ArithPkg::word16 memRdata
);
	import convMemPkg::*;

	logic hostRead;
	logic engRead;

	// Host always wins
	assign hostGrant = hostReq.valid;
	assign engGrant = engReq.valid && !hostReq.valid;

	always_comb
	begin
		if (hostGrant)
			memCmd = hostReq;
		else if (engGrant)
			memCmd = engReq;
		else
			memCmd = '0;
	end

	////////////////////////////////////////
	// Read data routing
	////////////////////////////////////////

	// Owner of the read data due next cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hostRead <= 1'b0;
			engRead <= 1'b0;
		end
		else
		begin
			hostRead <= hostGrant && !hostReq.write;
			engRead <= engGrant && !engReq.write;
		end
	end

	assign hostRsp.rvalid = hostRead;
	assign hostRsp.rdata = hostRead ? memRdata : '0;
	assign engRsp.rvalid = engRead;
	assign engRsp.rdata = engRead ? memRdata : '0;

endmodule

// ==== satShifter.sv ====
`timescale 1ns/1ps
`include "convolve_settings.svh"

module satShifter (
	input logic clk,
	input logic reset,
	input logic ready,
	input g729ArithPkg::word32 value,
	output g729ArithPkg::word32 result,
	output logic done
);
	import g729ArithPkg::*;

	localparam int cntW = $clog2(`CONV_SHIFT + 1);

	logic [cntW-1:0] count;
	word32 acc;

	// Shifts left to do, done follows the last one
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= count == cntW'(1);
			if (ready)
				count <= cntW'(`CONV_SHIFT);
			else if (count != '0)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ready)
			acc <= value;
		else if (count != '0)
		begin
			// Sign would flip, so clamp
			if (acc[31] != acc[30])
				acc <= acc[31] ? minWord32 : maxWord32;
			else
				acc <= acc <<< 1;
		end
	end

	assign result = acc;

endmodule

// ==== scratchMem.sv ====
`timescale 1ns/1ps
`include "convolve_settings.svh"

module scratchMem (
	input logic clk,
	input convMemPkg::memReq_t cmd,
	output g729ArithPkg::word16 rdata
);
	import g729ArithPkg::*;

	localparam int depth = 2 ** `CONV_ADDR_W;

	word16 mem [depth];

	// Single port, read data registered
	always_ff @(posedge clk)
	begin
		if (cmd.valid)
		begin
			if (cmd.write)
				mem[cmd.addr] <= cmd.wdata;
			else
				rdata <= mem[cmd.addr];
		end
	end

endmodule

// ==== sim.f ====
+incdir+.
g729ArithPkg.sv
convMemPkg.sv
scratchMem.sv
satShifter.sv
memArbiter.sv
apbHostPort.sv
convolve.sv
convolveTop.sv
convolve_assertions.sv
tb_convolveTop.sv

// ==== tb_convolveTop.sv ====
`timescale 1ns/1ps
`include "convolve_settings.svh"

module tb_convolveTop;
	import g729ArithPkg::*;
	import convMemPkg::*;

	localparam int vecLen = `CONV_VEC_LEN;
	localparam int idxW = `CONV_ADDR_W - `CONV_BLOCK_W;
	localparam int caseWords = 3 + 3 * vecLen;
	localparam int caseCount = 2;
	localparam int probeCount = 4;
	localparam int probeBase = caseCount * caseWords;
	localparam int stimWords = probeBase + probeCount;
	// Worst case per convolution, host stalls included
	localparam int runCycles = (vecLen * (vecLen + 1) / 2) * 12 + vecLen * 16;
	localparam int runCount = 4;
	localparam int apbCycles = 4000;
	localparam int watchdogCycles = runCount * runCycles + apbCycles;
	localparam int transferLimit = 64;

	localparam status_t statusIdle = '{done: 1'b0, busy: 1'b0};
	localparam status_t statusBusy = '{done: 1'b0, busy: 1'b1};
	localparam status_t statusDone = '{done: 1'b1, busy: 1'b0};

	logic clk;
	logic reset;
	apbReq_t apbReq;
	apbRsp_t apbRsp;
	logic [15:0] stim [stimWords];
	logic [15:0] lfsr;

	convolveTop dut0 (
		.clk(clk),
		.reset(reset),
		.apbReq(apbReq),
		.apbRsp(apbRsp)
	);

	bind convolveTop convolve_assertions assert0 (
		.clk(clk),
		.reset(reset),
		.hostReq(hostReq),
		.engReq(engReq),
		.hostGrant(hostGrant),
		.engGrant(engGrant),
		.memCmd(memCmd),
		.apbReq(apbReq),
		.apbRsp(apbRsp),
		.shiftReady(shiftReady),
		.shiftDone(shiftDone)
	);

	always #5 clk = ~clk;

	////////////////////////////////////////
	// Reporting and compare
	////////////////////////////////////////

	task automatic stopWithFailure(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic checkWord(input string name, input word16 got, input word16 exp);
		if (got !== exp)
			stopWithFailure($sformatf("mismatch at %0d ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic checkStatus(input string name, input status_t got, input status_t exp);
		if (got !== exp)
			stopWithFailure($sformatf(
				"mismatch at %0d ns: %s got busy=%b done=%b expected busy=%b done=%b",
				$time, name, got.busy, got.done, exp.busy, exp.done));
	endtask

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomBits(input int count, output int value);
		int b;
		value = 0;
		for (b = 0; b < count; b++)
		begin
			lfsr = lfsrNext(lfsr);
			value = (value << 1) | lfsr[0];
		end
	endtask

	////////////////////////////////////////
	// APB transfers
	////////////////////////////////////////

	task automatic apbTransfer(input logic write, input apbAddr addr, input apbData wdata,
			input logic expectErr, output apbData rdata);
		int waitCycles;
		@(posedge clk);
		apbReq.psel <= 1'b1;
		apbReq.penable <= 1'b0;
		apbReq.pwrite <= write;
		apbReq.paddr <= addr;
		apbReq.pwdata <= wdata;
		@(posedge clk);
		apbReq.penable <= 1'b1;
		waitCycles = 0;
		// Response sampled mid cycle
		@(negedge clk);
		while (!apbRsp.pready)
		begin
			waitCycles++;
			if (waitCycles > transferLimit)
				stopWithFailure($sformatf("APB transfer to address %h never completed", addr));
			@(negedge clk);
		end
		rdata = apbRsp.prdata;
		if (apbRsp.pslverr !== expectErr)
			stopWithFailure($sformatf("mismatch at %0d ns: pslverr at %h got %b expected %b",
				$time, addr, apbRsp.pslverr, expectErr));
		@(posedge clk);
		apbReq.psel <= 1'b0;
		apbReq.penable <= 1'b0;
	endtask

	function automatic apbAddr windowAddr(input memAddr a);
		apbAddr r;
		r = '0;
		r[`CONV_MEM_WINDOW] = 1'b1;
		r[`CONV_ADDR_W-1:0] = a;
		return r;
	endfunction

	function automatic memAddr wordAddr(input logic [15:0] blk, input int idx);
		return {blockIdx'(blk), idxW'(idx)};
	endfunction

	task automatic writeReg(input regAddr addr, input apbData data);
		apbData unused;
		apbTransfer(1'b1, apbAddr'(addr), data, 1'b0, unused);
	endtask

	task automatic readReg(input regAddr addr, output apbData data);
		apbTransfer(1'b0, apbAddr'(addr), '0, 1'b0, data);
	endtask

	task automatic writeMem(input memAddr addr, input word16 data);
		apbData unused;
		apbTransfer(1'b1, windowAddr(addr), data, 1'b0, unused);
	endtask

	task automatic readMem(input memAddr addr, output word16 data);
		apbData raw;
		apbTransfer(1'b0, windowAddr(addr), '0, 1'b0, raw);
		data = raw;
	endtask

	task automatic readStatus(output status_t s);
		apbData raw;
		readReg(regStatus, raw);
		s = status_t'(raw[1:0]);
	endtask

	////////////////////////////////////////
	// Case handling
	////////////////////////////////////////

	task automatic setBases(input int c, input int yOffset);
		int base;
		base = c * caseWords;
		writeReg(regXBase, stim[base]);
		writeReg(regHBase, stim[base + 1]);
		writeReg(regYBase, stim[base + 2] + yOffset);
	endtask

	task automatic loadVectors(input int c);
		int base;
		int k;
		base = c * caseWords;
		for (k = 0; k < vecLen; k++)
		begin
			writeMem(wordAddr(stim[base], k), stim[base + 3 + k]);
			writeMem(wordAddr(stim[base + 1], k), stim[base + 3 + vecLen + k]);
		end
	endtask

	task automatic checkResults(input int c, input int yOffset);
		int base;
		int k;
		word16 got;
		base = c * caseWords;
		for (k = 0; k < vecLen; k++)
		begin
			readMem(wordAddr(stim[base + 2] + yOffset, k), got);
			checkWord($sformatf("y[%0d]", k), got, stim[base + 3 + 2 * vecLen + k]);
		end
	endtask

	task automatic waitForDone();
		status_t s;
		int polls;
		polls = 0;
		readStatus(s);
		while (!s.done)
		begin
			polls++;
			if (polls > runCycles)
				stopWithFailure("engine never raised the done flag");
			readStatus(s);
		end
		checkStatus("STATUS at end of run", s, statusDone);
	endtask

	// Random host reads of x compete with the running engine
	task automatic readWhileBusy(input int c);
		status_t s;
		int base;
		int pick;
		int reads;
		word16 got;
		base = c * caseWords;
		reads = 0;
		readStatus(s);
		while (!s.done)
		begin
			randomBits(6, pick);
			pick = pick % vecLen;
			readMem(wordAddr(stim[base], pick), got);
			checkWord($sformatf("x[%0d] during run", pick), got, stim[base + 3 + pick]);
			reads++;
			if (reads > runCycles)
				stopWithFailure("engine never raised the done flag under host reads");
			readStatus(s);
		end
		checkStatus("STATUS after contended run", s, statusDone);
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial
	begin
		#(watchdogCycles * 10);
		stopWithFailure("watchdog expired before the tests finished");
	end

	initial
	begin
		status_t s;
		apbData data;
		int k;
		clk = 1'b0;
		reset = 1'b1;
		apbReq = '0;
		lfsr = 16'd26;
		$readmemh("convolve_input.txt", stim);
		if ($isunknown(stim[stimWords - 1]))
			stopWithFailure("convolve_input.txt is missing or incomplete");
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// Registers after reset and base readback
		readStatus(s);
		checkStatus("STATUS after reset", s, statusIdle);
		setBases(0, 0);
		readReg(regXBase, data);
		checkWord("XBASE", word16'(data), word16'(stim[0]));
		readReg(regHBase, data);
		checkWord("HBASE", word16'(data), word16'(stim[1]));
		readReg(regYBase, data);
		checkWord("YBASE", word16'(data), word16'(stim[2]));

		// Small values
		loadVectors(0);
		writeReg(regCtrl, 16'h0001);
		waitForDone();
		checkResults(0, 0);

		// Saturation, with a second start while busy
		setBases(1, 0);
		loadVectors(1);
		writeReg(regCtrl, 16'h0001);
		writeReg(regCtrl, 16'h0001);
		waitForDone();
		repeat (100) @(posedge clk);
		readStatus(s);
		checkStatus("STATUS long after run", s, statusDone);
		checkResults(1, 0);
		setBases(1, 8);
		writeReg(regCtrl, 16'h0001);
		readStatus(s);
		checkStatus("STATUS after restart", s, statusBusy);
		waitForDone();
		checkResults(1, 8);

		// Host reads during a run, results in a fresh y block
		setBases(0, 8);
		writeReg(regCtrl, 16'h0001);
		readWhileBusy(0);
		checkResults(0, 8);

		// Unmapped registers and STATUS writes
		for (k = 0; k < probeCount; k++)
		begin
			apbTransfer(1'b0, apbAddr'(stim[probeBase + k]), '0, 1'b1, data);
			apbTransfer(1'b1, apbAddr'(stim[probeBase + k]), 16'h001f, 1'b1, data);
		end
		apbTransfer(1'b1, apbAddr'(regStatus), 16'h0003, 1'b1, data);
		readReg(regXBase, data);
		checkWord("XBASE after probes", word16'(data), word16'(stim[0]));
		readReg(regHBase, data);
		checkWord("HBASE after probes", word16'(data), word16'(stim[1]));
		readReg(regYBase, data);
		checkWord("YBASE after probes", word16'(data), word16'(stim[2] + 8));
		readStatus(s);
		checkStatus("STATUS after probes", s, statusDone);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule
